// File: src/scan_index_pkg.sv
package scan_index_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// window types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] angle_t;	// 0.0001 deg counts
	typedef logic [15:0] reso_t;	// deg per point in the same units
	typedef logic [15:0] index_t;	// point index or count

	// mounting offset of 90 deg
	localparam angle_t ANGLE_OFFSET_DFLT = 32'd900000;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// index limits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam index_t INDEX_MAX_COARSE = 16'd3600;
	localparam index_t INDEX_MAX_FINE = 16'd7200;
	localparam reso_t RESO_FINE = 16'd500;	// selects the fine limit

	// input latch contents after reset
	localparam reso_t RESO_RST = 16'd1000;
	localparam angle_t START_ANGLE_RST = 32'hFFF2_4460;	// -90 deg
	localparam angle_t STOP_ANGLE_RST = 32'h0029_32E0;	// 270 deg

endpackage

// File: src/div_pkg.sv
package div_pkg;

	typedef logic [31:0] dividend_t;
	typedef logic [15:0] divisor_t;
	typedef logic [15:0] quotient_t;	// low half of full quotient

	localparam int DIV_STEPS = 32;	// one quotient bit per clock

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_t;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUSY,
		ARB_RELEASE	// one dead cycle after a divide
	} arb_state_t;

endpackage

// File: src/div_if.sv
interface div_if import div_pkg::*; ();

	logic		cal_sig;	// request level
	dividend_t	dividend;
	divisor_t	divisor;
	quotient_t	quotient;
	logic		cal_done;	// one-cycle pulse

	modport client (
		output	cal_sig,
		output	dividend,
		output	divisor,
		input	quotient,
		input	cal_done
	);

	modport server (
		input	cal_sig,
		input	dividend,
		input	divisor,
		output	quotient,
		output	cal_done
	);

endinterface

// File: src/serial_divider.sv
module serial_divider import div_pkg::*; (
	input	logic	i_clk_50m,
	input	logic	i_rst_n,
	div_if.server	s_div
);

	div_state_t	r_state;
	logic [4:0]	r_bit_cnt;
	dividend_t	r_rem;
	dividend_t	r_quo;	// dividend shifts out, quotient shifts in
	divisor_t	r_divisor;
	dividend_t	w_rem_shift;
	logic [32:0]	w_diff;

	assign w_rem_shift = {r_rem[30:0], r_quo[31]};
	assign w_diff = {1'b0, w_rem_shift} - {17'd0, r_divisor};	// msb set means no fit

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state <= DIV_IDLE;
			r_bit_cnt <= '0;
		end else begin
			case (r_state)
				DIV_IDLE: begin
					if (s_div.cal_sig) begin
						r_state <= DIV_RUN;
						r_bit_cnt <= '0;
					end
				end
				DIV_RUN: begin
					r_bit_cnt <= r_bit_cnt + 5'd1;
					if (r_bit_cnt == 5'(DIV_STEPS - 1))
						r_state <= DIV_DONE;
				end
				DIV_DONE: r_state <= DIV_IDLE;
				default: r_state <= DIV_IDLE;
			endcase
		end
	end

	// shift-subtract datapath
	always_ff @(posedge i_clk_50m) begin
		if (r_state == DIV_IDLE && s_div.cal_sig) begin
			r_rem <= '0;
			r_quo <= s_div.dividend;
			r_divisor <= s_div.divisor;
		end else if (r_state == DIV_RUN) begin
			if (!w_diff[32]) begin
				r_rem <= w_diff[31:0];
				r_quo <= {r_quo[30:0], 1'b1};
			end else begin
				r_rem <= w_rem_shift;
				r_quo <= {r_quo[30:0], 1'b0};
			end
		end
	end

	// zero divisor always fits, so all ones
	assign s_div.quotient = r_quo[15:0];
	assign s_div.cal_done = (r_state == DIV_DONE);

endmodule

// File: src/div_arbiter.sv
module div_arbiter import div_pkg::*; (
	input	logic	i_clk_50m,
	input	logic	i_rst_n,
	div_if.server	s_ch0,
	div_if.server	s_ch1,
	div_if.client	c_div
);

	arb_state_t	r_state;
	logic		r_grant;	// 0 ch0, 1 ch1
	logic		r_last;	// last channel served
	logic		w_busy;

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state <= ARB_IDLE;
			r_grant <= 1'b0;
			r_last <= 1'b1;	// ch0 wins the first tie
		end else begin
			case (r_state)
				ARB_IDLE: begin
					if (s_ch0.cal_sig || s_ch1.cal_sig) begin
						r_state <= ARB_BUSY;
						if (s_ch0.cal_sig && s_ch1.cal_sig)
							r_grant <= ~r_last;
						else
							r_grant <= s_ch1.cal_sig;
					end
				end
				ARB_BUSY: begin
					if (c_div.cal_done) begin
						r_state <= ARB_RELEASE;
						r_last <= r_grant;
					end
				end
				ARB_RELEASE: r_state <= ARB_IDLE;	// let the request drop
				default: r_state <= ARB_IDLE;
			endcase
		end
	end

	assign w_busy = (r_state == ARB_BUSY);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request mux and result steering
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign c_div.cal_sig = w_busy & (r_grant ? s_ch1.cal_sig : s_ch0.cal_sig);
	assign c_div.dividend = r_grant ? s_ch1.dividend : s_ch0.dividend;
	assign c_div.divisor = r_grant ? s_ch1.divisor : s_ch0.divisor;

	assign s_ch0.cal_done = w_busy & ~r_grant & c_div.cal_done;
	assign s_ch1.cal_done = w_busy & r_grant & c_div.cal_done;
	assign s_ch0.quotient = r_grant ? '0 : c_div.quotient;
	assign s_ch1.quotient = r_grant ? c_div.quotient : '0;

endmodule

// File: src/index_calculate.sv
module index_calculate import scan_index_pkg::*, div_pkg::*; #(
	parameter angle_t ANGLE_OFFSET = ANGLE_OFFSET_DFLT
) (
	input	logic	i_clk_50m,
	input	logic	i_rst_n,
	input	reso_t	i_angle_reso,
	input	angle_t	i_start_angle,
	input	angle_t	i_stop_angle,
	div_if.client	c_div,
	output	index_t	o_start_index,
	output	index_t	o_stop_index,
	output	index_t	o_index_num
);

	typedef enum logic [2:0] {
		IDLE,
		ASSIGN,
		START,
		STOP,
		END,
		OUTPUT
	} calc_state_t;

	calc_state_t	r_state;
	reso_t		r_angle_reso;
	angle_t		r_start_angle;
	angle_t		r_stop_angle;
	index_t		r_index_max;
	angle_t		r_start_angle_c;
	angle_t		r_stop_angle_c;
	index_t		r_start_index;
	index_t		r_stop_index;
	index_t		r_index_num_pre;
	index_t		r_index_num;
	index_t		r_start_index1;
	index_t		r_stop_index1;
	index_t		r_start_index2;
	index_t		r_stop_index2;
	logic		r_cal_sig;
	dividend_t	r_dividend;
	divisor_t	r_divisor;

	// input latches
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_angle_reso <= RESO_RST;
			r_start_angle <= START_ANGLE_RST;
			r_stop_angle <= STOP_ANGLE_RST;
			r_index_max <= INDEX_MAX_COARSE;
		end else begin
			r_angle_reso <= i_angle_reso;
			r_start_angle <= i_start_angle;
			r_stop_angle <= i_stop_angle;
			r_index_max <= (r_angle_reso == RESO_FINE) ? INDEX_MAX_FINE : INDEX_MAX_COARSE;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// window loop
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state <= IDLE;
			r_cal_sig <= 1'b0;
			r_start_index <= '0;
			r_stop_index <= INDEX_MAX_COARSE;
			r_index_num_pre <= INDEX_MAX_COARSE;
			r_index_num <= INDEX_MAX_COARSE;
		end else begin
			case (r_state)
				IDLE: begin
					r_cal_sig <= 1'b0;
					r_state <= ASSIGN;
				end
				ASSIGN: r_state <= START;	// offset add happens here
				START: begin
					if (c_div.cal_done) begin
						r_cal_sig <= 1'b0;
						r_start_index <= c_div.quotient;
						r_state <= STOP;
					end else begin
						r_cal_sig <= 1'b1;
					end
				end
				STOP: begin
					if (c_div.cal_done) begin
						r_cal_sig <= 1'b0;
						r_stop_index <= c_div.quotient;
						r_state <= END;
					end else begin
						r_cal_sig <= 1'b1;
					end
				end
				END: begin
					if (r_stop_index >= r_start_index)
						r_index_num_pre <= r_stop_index - r_start_index + 16'd1;
					else
						r_index_num_pre <= r_start_index - r_stop_index + 16'd1;
					r_state <= OUTPUT;
				end
				OUTPUT: begin
					if (r_index_num_pre >= r_index_max)
						r_index_num <= r_index_max;	// clamp
					else
						r_index_num <= r_index_num_pre;
					r_state <= IDLE;
				end
				default: r_state <= IDLE;
			endcase
		end
	end

	// operands only move while no request is up
	always_ff @(posedge i_clk_50m) begin
		if (r_state == ASSIGN) begin
			r_start_angle_c <= r_start_angle + ANGLE_OFFSET;
			r_stop_angle_c <= r_stop_angle + ANGLE_OFFSET;
		end
		if (!r_cal_sig) begin
			r_dividend <= (r_state == STOP) ? r_stop_angle_c : r_start_angle_c;
			r_divisor <= r_angle_reso;
		end
	end

	assign c_div.cal_sig = r_cal_sig;
	assign c_div.dividend = r_dividend;
	assign c_div.divisor = r_divisor;

	// two-stage output delay
	always_ff @(posedge i_clk_50m or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_start_index1 <= '0;
			r_stop_index1 <= INDEX_MAX_COARSE;
			r_start_index2 <= '0;
			r_stop_index2 <= INDEX_MAX_COARSE;
		end else begin
			r_start_index1 <= r_start_index;
			r_stop_index1 <= r_stop_index;
			r_start_index2 <= r_start_index1;
			r_stop_index2 <= r_stop_index1;
		end
	end

	assign o_start_index = r_start_index2;
	assign o_stop_index = r_stop_index2;
	assign o_index_num = r_index_num;

endmodule

// File: src/scan_window_top.sv
module scan_window_top import scan_index_pkg::*; #(
	parameter angle_t ANGLE_OFFSET = ANGLE_OFFSET_DFLT
) (
	input	logic	i_clk_50m,
	input	logic	i_rst_n,
	input	reso_t	i_angle_reso,
	input	angle_t	i_win0_start_angle,
	input	angle_t	i_win0_stop_angle,
	input	angle_t	i_win1_start_angle,
	input	angle_t	i_win1_stop_angle,
	output	index_t	o_win0_start_index,
	output	index_t	o_win0_stop_index,
	output	index_t	o_win0_index_num,
	output	index_t	o_win1_start_index,
	output	index_t	o_win1_stop_index,
	output	index_t	o_win1_index_num
);

	div_if ch0 ();
	div_if ch1 ();
	div_if srv ();	// arbiter to divider

	index_calculate #(.ANGLE_OFFSET(ANGLE_OFFSET)) u_win0 (
		.i_clk_50m		(i_clk_50m),
		.i_rst_n		(i_rst_n),
		.i_angle_reso	(i_angle_reso),
		.i_start_angle	(i_win0_start_angle),
		.i_stop_angle	(i_win0_stop_angle),
		.c_div			(ch0.client),
		.o_start_index	(o_win0_start_index),
		.o_stop_index	(o_win0_stop_index),
		.o_index_num	(o_win0_index_num)
	);

	index_calculate #(.ANGLE_OFFSET(ANGLE_OFFSET)) u_win1 (
		.i_clk_50m		(i_clk_50m),
		.i_rst_n		(i_rst_n),
		.i_angle_reso	(i_angle_reso),
		.i_start_angle	(i_win1_start_angle),
		.i_stop_angle	(i_win1_stop_angle),
		.c_div			(ch1.client),
		.o_start_index	(o_win1_start_index),
		.o_stop_index	(o_win1_stop_index),
		.o_index_num	(o_win1_index_num)
	);

	div_arbiter u_arb (
		.i_clk_50m	(i_clk_50m),
		.i_rst_n	(i_rst_n),
		.s_ch0		(ch0.server),
		.s_ch1		(ch1.server),
		.c_div		(srv.client)
	);

	serial_divider u_div (
		.i_clk_50m	(i_clk_50m),
		.i_rst_n	(i_rst_n),
		.s_div		(srv.server)
	);

endmodule

// File: dv/tb_scan_window.sv
module tb_scan_window;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int VECTORS = 12;
	localparam int SETTLE_CYCLES = 320;	// two loops plus margin
	localparam int TIMEOUT_CYCLES = 8 * VECTORS * SETTLE_CYCLES + 1000;
	localparam logic [31:0] ANGLE_LO = 32'hFFF2_4460;	// -90 deg
	localparam logic [31:0] ANGLE_HI = 32'd2699999;

	logic clk_50m;
	logic rst_n;
	logic [15:0] angle_reso;
	logic [31:0] win0_start, win0_stop, win1_start, win1_stop;
	logic [15:0] win0_start_idx, win0_stop_idx, win0_num;
	logic [15:0] win1_start_idx, win1_stop_idx, win1_num;
	logic [31:0] lfsr = 32'hb3a9_91eb;
	int cycle_cnt = 0;
	int test_errs = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	scan_window_top uut (
		.i_clk_50m(clk_50m), .i_rst_n(rst_n), .i_angle_reso(angle_reso),
		.i_win0_start_angle(win0_start), .i_win0_stop_angle(win0_stop),
		.i_win1_start_angle(win1_start), .i_win1_stop_angle(win1_stop),
		.o_win0_start_index(win0_start_idx), .o_win0_stop_index(win0_stop_idx),
		.o_win0_index_num(win0_num), .o_win1_start_index(win1_start_idx),
		.o_win1_stop_index(win1_stop_idx), .o_win1_index_num(win1_num)
	);

	initial clk_50m = 1'b0;
	always #10 clk_50m = ~clk_50m;	// 50 MHz

	always @(posedge clk_50m) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// random source and reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// x^32+x^22+x^2+x+1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int k;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[31]};
		end
		return v;
	endfunction

	function automatic logic [31:0] rand_angle();
		return rand_bits(22) % 32'd3600000 + ANGLE_LO;	// -900000 .. 2699999
	endfunction

	function automatic logic [15:0] draw_reso();
		logic [31:0] r;
		r = 32'd500;
		while (r == 32'd500)
			r = 32'd250 + rand_bits(12) % 32'd3751;
		return r[15:0];
	endfunction

	function automatic logic [15:0] model_index(input logic [31:0] angle, input logic [15:0] reso);
		logic [31:0] q;
		q = (angle + 32'd900000) / {16'd0, reso};
		return q[15:0];	// low half only
	endfunction

	function automatic logic [15:0] model_count(input logic [15:0] a, input logic [15:0] b,
			input logic [15:0] reso);
		logic [15:0] n;
		logic [15:0] cap;
		n = (b >= a) ? b - a + 16'd1 : a - b + 16'd1;
		cap = (reso == 16'd500) ? 16'd7200 : 16'd3600;
		return (n > cap) ? cap : n;
	endfunction

	task automatic check_value(input string field, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, field, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_outputs();
		logic [15:0] s0, p0, s1, p1;
		s0 = model_index(win0_start, angle_reso);
		p0 = model_index(win0_stop, angle_reso);
		s1 = model_index(win1_start, angle_reso);
		p1 = model_index(win1_stop, angle_reso);
		check_value("win0 start_index", win0_start_idx, s0);
		check_value("win0 stop_index", win0_stop_idx, p0);
		check_value("win0 index_num", win0_num, model_count(s0, p0, angle_reso));
		check_value("win1 start_index", win1_start_idx, s1);
		check_value("win1 stop_index", win1_stop_idx, p1);
		check_value("win1 index_num", win1_num, model_count(s1, p1, angle_reso));
	endtask

	task automatic run_vector(input logic [15:0] r, input logic [31:0] s0, input logic [31:0] p0,
			input logic [31:0] s1, input logic [31:0] p1);
		@(posedge clk_50m);
		#2;
		angle_reso = r;
		win0_start = s0;
		win0_stop = p0;
		win1_start = s1;
		win1_stop = p1;
		repeat (SETTLE_CYCLES) @(posedge clk_50m);
		#1;
		check_outputs();
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0) begin
			tests_passed++;
			$display("%s: done, no errors", name);
		end else begin
			tests_failed++;
			$display("%s: done, %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// test sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin
		logic [31:0] a, b, c, d;
		int v;
		rst_n = 1'b0;
		angle_reso = 16'd1000;	// same as the input latch reset values
		win0_start = ANGLE_LO;
		win0_stop = 32'd2700000;
		win1_start = ANGLE_LO;
		win1_stop = 32'd2700000;
		repeat (10) @(posedge clk_50m);
		#2 rst_n = 1'b1;
		@(posedge clk_50m);
		#1;
		check_value("win0 start_index", win0_start_idx, 16'd0);
		check_value("win0 stop_index", win0_stop_idx, 16'd3600);
		check_value("win0 index_num", win0_num, 16'd3600);
		check_value("win1 start_index", win1_start_idx, 16'd0);
		check_value("win1 stop_index", win1_stop_idx, 16'd3600);
		check_value("win1 index_num", win1_num, 16'd3600);
		end_test("reset values");

		for (v = 0; v < VECTORS; v++) begin
			a = rand_angle();
			b = rand_angle();
			run_vector(16'd1000, a, b, a, b);	// same window on both
		end
		end_test("random windows at 1000");

		for (v = 0; v < VECTORS; v++) begin
			a = ANGLE_LO + rand_bits(8);
			b = ANGLE_HI - rand_bits(8);
			c = ANGLE_LO + rand_bits(16);
			d = ANGLE_HI - rand_bits(16);
			run_vector(16'd500, a, b, c, d);
		end
		end_test("wide windows at 500");

		for (v = 0; v < VECTORS; v++) begin
			a = rand_angle();
			b = rand_angle();
			if ($signed(a) < $signed(b))
				run_vector(16'd1000, b, a, b, a);
			else
				run_vector(16'd1000, a, b, a, b);
		end
		end_test("reversed windows");

		for (v = 0; v < VECTORS; v++) begin
			a = rand_angle();
			b = rand_angle();
			c = rand_angle();
			d = rand_angle();
			run_vector(16'd1000, a, b, c, d);	// both channels contend
		end
		end_test("independent windows");

		for (v = 0; v < VECTORS; v++) begin
			a = rand_angle();
			b = rand_angle();
			c = rand_angle();
			d = rand_angle();
			run_vector(draw_reso(), a, b, c, d);
		end
		end_test("other resolutions");

		$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: scan_window.f
src/scan_index_pkg.sv
src/div_pkg.sv
src/div_if.sv
src/serial_divider.sv
src/div_arbiter.sv
src/index_calculate.sv
src/scan_window_top.sv
dv/tb_scan_window.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the scan window testbench with Verilator.
set -u
set -o pipefail

cd "$(dirname "$0")" || exit 1

if ! verilator --binary -f scan_window.f --top-module tb_scan_window -o tb_scan_window; then
	echo "verilator build failed"
	exit 1
fi

if ! ./obj_dir/tb_scan_window 2>&1 | tee sim.log; then
	echo "simulation exited with an error"
	exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed, see sim.log"
exit 1
